// ==== Bender.yml ====
package:
  name: motion_io

sources:
  - include_dirs:
      - include
    files:
      - hw/motion_pkg.sv
      - hw/frame_parser.sv
      - hw/step_sequencer.sv
      - hw/pwm_bank.sv
      - hw/shutdown_guard.sv
      - hw/motion_io.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/motion_io_checker.sv
      - tests/motion_io_tb.sv

// ==== hw/frame_parser.sv ====
module frame_parser import motion_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] msg_data,
	input  logic       msg_valid,
	output logic       msg_ready,
	output cmd_t       move_cmd,
	output logic       move_valid,
	input  logic       move_ready,
	output cmd_t       pwm_cmd,
	output logic       pwm_valid,
	input  logic       pwm_ready,
	output logic       clear_pulse,
	output logic       cmd_seen,
	output logic       frame_error
);

	typedef enum logic [2:0] {
		ST_OP,
		ST_CH,
		ST_HI,
		ST_LO,
		ST_DISPATCH
	} state_e;

	state_e     state;
	logic [7:0] op_byte;
	opcode_e    op;
	cmd_t       cmd;
	logic       accept;
	logic       op_known;

	assign msg_ready = state != ST_DISPATCH; // Stalls the link until the engine takes the command.
	assign accept = msg_valid && msg_ready;
	assign op_known = op_byte == OP_MOVE || op_byte == OP_PWM || op_byte == OP_CLEAR;

	assign move_cmd = cmd;
	assign pwm_cmd = cmd;
	assign move_valid = state == ST_DISPATCH && op == OP_MOVE;
	assign pwm_valid = state == ST_DISPATCH && op == OP_PWM;
	assign clear_pulse = state == ST_DISPATCH && op == OP_CLEAR; // Needs no handshake.
	assign cmd_seen = (move_valid && move_ready) || (pwm_valid && pwm_ready) || clear_pulse;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_OP;
			frame_error <= 1'b0;
		end else begin
			case (state)
				ST_OP: if (accept) begin
					op_byte <= msg_data;
					state <= ST_CH;
				end
				ST_CH: if (accept) begin
					cmd.channel <= msg_data;
					state <= ST_HI;
				end
				ST_HI: if (accept) begin
					cmd.arg[15:8] <= msg_data;
					state <= ST_LO;
				end
				ST_LO: if (accept) begin
					cmd.arg[7:0] <= msg_data;
					if (op_known) begin
						op <= opcode_e'(op_byte);
						state <= ST_DISPATCH;
					end else begin
						frame_error <= 1'b1; // The flag is sticky and the frame is dropped.
						state <= ST_OP;
					end
				end
				ST_DISPATCH: if (cmd_seen) begin
					state <= ST_OP;
				end
				default: state <= ST_OP;
			endcase
		end
	end

endmodule

// ==== hw/motion_io.sv ====
`include "motion_macros.svh"

module motion_io import motion_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [7:0]               msg_data,
	input  logic                     msg_valid,
	output logic                     msg_ready,
	input  logic [`MOTION_NSTEP-1:0] endstop,
	output logic [`MOTION_NSTEP-1:0] step,
	output logic [`MOTION_NSTEP-1:0] dir,
	output logic [`MOTION_NPWM-1:0]  pwm,
	output pos_t                     position [`MOTION_NSTEP],
	output logic                     shutdown,
	output cause_e                   cause,
	output logic                     frame_error
);

	cmd_t                    move_cmd;
	logic                    move_valid;
	logic                    move_ready;
	cmd_t                    pwm_cmd;
	logic                    pwm_valid;
	logic                    pwm_ready;
	logic                    clear_pulse;
	logic                    cmd_seen;
	logic                    abort;
	logic                    armed_req;
	axis_out_t               raw_axis;
	logic [`MOTION_NPWM-1:0] raw_pwm;

	frame_parser frame_parser_i (
		.clk(clk),
		.reset(reset),
		.msg_data(msg_data),
		.msg_valid(msg_valid),
		.msg_ready(msg_ready),
		.move_cmd(move_cmd),
		.move_valid(move_valid),
		.move_ready(move_ready),
		.pwm_cmd(pwm_cmd),
		.pwm_valid(pwm_valid),
		.pwm_ready(pwm_ready),
		.clear_pulse(clear_pulse),
		.cmd_seen(cmd_seen),
		.frame_error(frame_error)
	);

	step_sequencer step_sequencer_i (
		.clk(clk),
		.reset(reset),
		.move_cmd(move_cmd),
		.move_valid(move_valid),
		.move_ready(move_ready),
		.abort(abort),
		.raw_axis(raw_axis),
		.position(position)
	);

	pwm_bank pwm_bank_i (
		.clk(clk),
		.reset(reset),
		.pwm_cmd(pwm_cmd),
		.pwm_valid(pwm_valid),
		.pwm_ready(pwm_ready),
		.raw_pwm(raw_pwm),
		.armed_req(armed_req)
	);

	shutdown_guard shutdown_guard_i (
		.clk(clk),
		.reset(reset),
		.raw_axis(raw_axis),
		.raw_pwm(raw_pwm),
		.endstop(endstop),
		.cmd_seen(cmd_seen),
		.armed_req(armed_req),
		.clear_pulse(clear_pulse),
		.abort(abort),
		.step(step),
		.dir(dir),
		.pwm(pwm),
		.shutdown(shutdown),
		.cause(cause)
	);

endmodule

// ==== hw/motion_pkg.sv ====
`include "motion_macros.svh"

package motion_pkg;

	// First byte of every frame.
	typedef enum logic [7:0] {
		OP_MOVE  = 8'h01,
		OP_PWM   = 8'h02,
		OP_CLEAR = 8'h03
	} opcode_e;

	typedef enum logic [1:0] {
		CAUSE_NONE     = 2'd0,
		CAUSE_ENDSTOP  = 2'd1,
		CAUSE_WATCHDOG = 2'd2
	} cause_e;

	// Channel byte and argument of a decoded frame.
	typedef struct packed {
		logic [7:0]  channel;
		logic [15:0] arg;
	} cmd_t;

	// In a move argument dir high counts the position up.
	typedef struct packed {
		logic        dir;
		logic [14:0] count;
	} move_t;

	typedef struct packed {
		logic [`MOTION_NSTEP-1:0] step;
		logic [`MOTION_NSTEP-1:0] dir;
		logic [`MOTION_NSTEP-1:0] moving;
	} axis_out_t;

	typedef logic signed [15:0] pos_t;

endpackage

// ==== hw/pwm_bank.sv ====
`include "motion_macros.svh"

module pwm_bank import motion_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  cmd_t                    pwm_cmd,
	input  logic                    pwm_valid,
	output logic                    pwm_ready,
	output logic [`MOTION_NPWM-1:0] raw_pwm,
	output logic                    armed_req
);

	localparam int CW = $clog2(`MOTION_NPWM);

	logic [7:0]    cnt;
	logic [7:0]    pending [`MOTION_NPWM];
	logic [7:0]    active [`MOTION_NPWM];
	logic [7:0]    duty;
	logic [CW-1:0] sel;
	logic          write;

	assign pwm_ready = 1'b1;
	assign duty = pwm_cmd.arg[7:0];
	assign sel = pwm_cmd.channel[CW-1:0];
	assign write = pwm_valid && pwm_ready;

	always_comb begin
		for (int i = 0; i < `MOTION_NPWM; i++)
			raw_pwm[i] = cnt < active[i];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			armed_req <= 1'b0;
			for (int i = 0; i < `MOTION_NPWM; i++) begin
				pending[i] <= '0;
				active[i] <= '0;
			end
		end else begin
			cnt <= cnt + 8'd1;
			armed_req <= write && duty != 8'd0;
			if (write)
				pending[sel] <= duty;
			if (cnt == 8'hff) begin
				// A write in the wrap cycle lands at once.
				for (int i = 0; i < `MOTION_NPWM; i++)
					active[i] <= (write && sel == i) ? duty : pending[i];
			end
		end
	end

endmodule

// ==== hw/shutdown_guard.sv ====
`include "motion_macros.svh"

module shutdown_guard import motion_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  axis_out_t                raw_axis,
	input  logic [`MOTION_NPWM-1:0]  raw_pwm,
	input  logic [`MOTION_NSTEP-1:0] endstop,
	input  logic                     cmd_seen,
	input  logic                     armed_req,
	input  logic                     clear_pulse,
	output logic                     abort,
	output logic [`MOTION_NSTEP-1:0] step,
	output logic [`MOTION_NSTEP-1:0] dir,
	output logic [`MOTION_NPWM-1:0]  pwm,
	output logic                     shutdown,
	output cause_e                   cause
);

	localparam int WW = $clog2(`WATCHDOG_CYCLES + 1);

	logic          armed;
	logic [WW-1:0] wd_cnt;
	logic          trip_endstop;
	logic          trip_watchdog;

	// Endstops only count while their axis is moving.
	assign trip_endstop = |(endstop & raw_axis.moving);
	assign trip_watchdog = armed && wd_cnt == WW'(`WATCHDOG_CYCLES);

	assign abort = shutdown;
	assign step = raw_axis.step & ~{`MOTION_NSTEP{shutdown}};
	assign pwm = raw_pwm & ~{`MOTION_NPWM{shutdown}};
	assign dir = raw_axis.dir;

	always_ff @(posedge clk) begin
		if (reset) begin
			armed <= 1'b0;
			wd_cnt <= '0;
			shutdown <= 1'b0;
			cause <= CAUSE_NONE;
		end else if (clear_pulse) begin
			armed <= 1'b0;
			wd_cnt <= '0;
			shutdown <= 1'b0;
			cause <= CAUSE_NONE;
		end else begin
			if (armed_req)
				armed <= 1'b1;
			if (!armed || cmd_seen)
				wd_cnt <= '0;
			else if (!trip_watchdog)
				wd_cnt <= wd_cnt + 1'b1; // Holds at the limit.
			if (!shutdown && (trip_endstop || trip_watchdog)) begin
				shutdown <= 1'b1;
				cause <= trip_endstop ? CAUSE_ENDSTOP : CAUSE_WATCHDOG;
			end
		end
	end

endmodule

// ==== hw/step_sequencer.sv ====
`include "motion_macros.svh"

module step_sequencer import motion_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  cmd_t      move_cmd,
	input  logic      move_valid,
	output logic      move_ready,
	input  logic      abort,
	output axis_out_t raw_axis,
	output pos_t      position [`MOTION_NSTEP]
);

	localparam int AW = $clog2(`MOTION_NSTEP);
	localparam int TW = $clog2(`STEP_HIGH_CYCLES + `STEP_LOW_CYCLES);

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_START,
		PH_HIGH,
		PH_LOW
	} phase_e;

	phase_e                   phase [`MOTION_NSTEP];
	logic [14:0]              remaining [`MOTION_NSTEP];
	logic [TW-1:0]            timer [`MOTION_NSTEP];
	logic [`MOTION_NSTEP-1:0] step_q;
	logic [`MOTION_NSTEP-1:0] dir_q;
	logic [`MOTION_NSTEP-1:0] moving;
	logic [AW-1:0]            sel;
	move_t                    mv;
	logic                     accept;

	assign mv = move_t'(move_cmd.arg);
	assign sel = move_cmd.channel[AW-1:0];
	assign move_ready = phase[sel] == PH_IDLE; // Only the addressed axis has to be free.
	assign accept = move_valid && move_ready;

	always_comb begin
		for (int i = 0; i < `MOTION_NSTEP; i++)
			moving[i] = phase[i] != PH_IDLE;
	end

	assign raw_axis = '{step: step_q, dir: dir_q, moving: moving};

	always_ff @(posedge clk) begin
		for (int i = 0; i < `MOTION_NSTEP; i++) begin
			if (reset) begin
				phase[i] <= PH_IDLE;
				remaining[i] <= '0;
				step_q[i] <= 1'b0;
				dir_q[i] <= 1'b0;
				position[i] <= '0;
			end else if (abort) begin
				phase[i] <= PH_IDLE; // Moves accepted now are dropped.
				remaining[i] <= '0;
				step_q[i] <= 1'b0;
			end else begin
				case (phase[i])
					PH_IDLE: if (accept && sel == i) begin
						dir_q[i] <= mv.dir;
						remaining[i] <= mv.count;
						if (mv.count != 15'd0)
							phase[i] <= PH_START;
					end
					PH_HIGH: if (timer[i] != '0) begin
						timer[i] <= timer[i] - 1'b1;
					end else begin
						step_q[i] <= 1'b0;
						timer[i] <= TW'(`STEP_LOW_CYCLES - 1);
						phase[i] <= PH_LOW;
					end
					default: if (phase[i] == PH_LOW && timer[i] != '0) begin
						timer[i] <= timer[i] - 1'b1;
					end else if (remaining[i] == 15'd0) begin
						phase[i] <= PH_IDLE;
					end else begin
						// Rising edge of the next step.
						step_q[i] <= 1'b1;
						timer[i] <= TW'(`STEP_HIGH_CYCLES - 1);
						remaining[i] <= remaining[i] - 15'd1;
						position[i] <= position[i] + (dir_q[i] ? 16'sd1 : -16'sd1);
						phase[i] <= PH_HIGH;
					end
				endcase
			end
		end
	end

endmodule

// ==== include/motion_macros.svh ====
`ifndef MOTION_MACROS_SVH
`define MOTION_MACROS_SVH

// Axis and channel counts.
`define MOTION_NSTEP 2
`define MOTION_NPWM 4

// Step pulse shape in clock cycles.
`define STEP_HIGH_CYCLES 4
`define STEP_LOW_CYCLES 4

// Longest gap between commands once the watchdog is armed.
`define WATCHDOG_CYCLES 200

`endif

// ==== sources.f ====
+incdir+include
hw/motion_pkg.sv
hw/frame_parser.sv
hw/step_sequencer.sv
hw/pwm_bank.sv
hw/shutdown_guard.sv
hw/motion_io.sv
tests/motion_io_checker.sv
tests/motion_io_tb.sv

// ==== tests/motion_io_checker.sv ====
`include "motion_macros.svh"

module motion_io_checker import motion_pkg::*; (
	input logic                     clk,
	input logic                     reset,
	input logic [7:0]               msg_data,
	input logic                     msg_valid,
	input logic                     msg_ready,
	input logic [`MOTION_NSTEP-1:0] step,
	input logic [`MOTION_NPWM-1:0]  pwm,
	input logic                     shutdown,
	input cause_e                   cause
);

	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;

	msg_hold: assert property (@(posedge clk) disable iff (reset)
		msg_valid && !msg_ready |=> $stable(msg_data))
		else begin
			failures++;
			$error("msg_data changed while the byte stream was stalled");
		end

	outputs_masked: assert property (@(posedge clk) disable iff (reset)
		shutdown |-> step == '0 && pwm == '0)
		else begin
			failures++;
			$error("step or pwm is active during shutdown");
		end

	cause_latched: assert property (@(posedge clk) disable iff (reset)
		shutdown |-> cause != CAUSE_NONE)
		else begin
			failures++;
			$error("shutdown is active without a cause");
		end

endmodule

bind motion_io motion_io_checker checker_i (.*);

// ==== tests/motion_io_tb.sv ====
`include "motion_macros.svh"

module motion_io_tb import motion_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 20000;

	logic                     clk;
	logic                     reset;
	logic [7:0]               msg_data;
	logic                     msg_valid;
	logic                     msg_ready;
	logic [`MOTION_NSTEP-1:0] endstop;
	logic [`MOTION_NSTEP-1:0] step;
	logic [`MOTION_NSTEP-1:0] dir;
	logic [`MOTION_NPWM-1:0]  pwm;
	pos_t                     position [`MOTION_NSTEP];
	logic                     shutdown;
	cause_e                   cause;
	logic                     frame_error;

	integer                   seed = 32'h281d;
	int                       value_errors = 0;
	int                       other_errors = 0;
	int                       step_cnt [`MOTION_NSTEP];
	int                       exp_pos [`MOTION_NSTEP];
	logic [`MOTION_NSTEP-1:0] exp_dir;
	logic [`MOTION_NSTEP-1:0] prev_step;
	logic [7:0]               duty [`MOTION_NPWM];
	int                       pwm_exp [`MOTION_NPWM];
	int                       hi_acc [`MOTION_NPWM];
	int                       tick;
	int                       win_id = 0;
	int                       check_win = 0;
	string                    pwm_name;

	motion_io motion_io_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int step_total(int count);
		return count & 32'h7fff; // Count field is 15 bits.
	endfunction

	function automatic int end_position(int start, logic d, int count);
		return d ? start + step_total(count) : start - step_total(count);
	endfunction

	function automatic int duty_high_cycles(int duty_val, logic masked);
		return masked ? 0 : duty_val;
	endfunction

	function automatic cause_e shutdown_cause(logic endstop_hit, logic silent);
		if (endstop_hit)
			return CAUSE_ENDSTOP; // Endstop wins when both trip together.
		return silent ? CAUSE_WATCHDOG : CAUSE_NONE;
	endfunction

	function automatic int error_total();
		return value_errors + other_errors + motion_io_i.checker_i.failures;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			value_errors++;
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic push_byte(input logic [7:0] b);
		repeat ({$random(seed)} % 3) @(negedge clk);
		msg_data = b;
		msg_valid = 1'b1;
		while (!msg_ready)
			@(negedge clk);
		@(negedge clk); // Taken on the edge just passed.
		msg_valid = 1'b0;
	endtask

	task automatic send_frame(input logic [7:0] op, input logic [7:0] ch, input logic [15:0] arg);
		push_byte(op);
		push_byte(ch);
		push_byte(arg[15:8]);
		push_byte(arg[7:0]);
	endtask

	task automatic run_move(input string name, input int axis, input logic d, input int count);
		int base;
		base = step_cnt[axis];
		exp_dir[axis] = d;
		send_frame(OP_MOVE, 8'(axis), {d, 15'(count)});
		while (step_cnt[axis] < base + step_total(count))
			@(negedge clk);
		repeat (`STEP_HIGH_CYCLES + `STEP_LOW_CYCLES + 2) @(negedge clk);
		exp_pos[axis] = end_position(exp_pos[axis], d, count);
		check_value({name, " steps"}, step_total(count), step_cnt[axis] - base);
		check_value({name, " position"}, exp_pos[axis], position[axis]);
	endtask

	task automatic measure_pwm(input string name, input logic masked);
		pwm_name = name;
		for (int c = 0; c < `MOTION_NPWM; c++)
			pwm_exp[c] = duty_high_cycles(duty[c], masked);
		check_win = win_id + 2; // First window that starts after this call.
		while (win_id < check_win)
			@(negedge clk);
	endtask

	// Counts rising steps and PWM high cycles. The tick follows the PWM counter.
	always @(posedge clk) begin
		if (reset) begin
			tick = 0;
			prev_step = '0;
			step_cnt = '{default: 0};
			hi_acc = '{default: 0};
		end else begin
			for (int i = 0; i < `MOTION_NSTEP; i++) begin
				if (step[i] && !prev_step[i]) begin
					step_cnt[i]++;
					check_value($sformatf("axis %0d dir", i), exp_dir[i], dir[i]);
				end
			end
			prev_step = step;
			for (int c = 0; c < `MOTION_NPWM; c++)
				hi_acc[c] += pwm[c];
			if (tick % 256 == 255) begin
				win_id++;
				for (int c = 0; c < `MOTION_NPWM; c++) begin
					if (win_id == check_win)
						check_value($sformatf("%s ch %0d", pwm_name, c), pwm_exp[c], hi_acc[c]);
					hi_acc[c] = 0;
				end
			end
			tick++;
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Errors: %0d total", error_total());
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		int base0;
		int base1;
		int taken;
		int silent;
		reset = 1'b1;
		msg_data = '0;
		msg_valid = 1'b0;
		endstop = '0;
		exp_dir = '0;
		exp_pos = '{default: 0};
		for (int c = 0; c < `MOTION_NPWM; c++)
			duty[c] = 8'({$random(seed)} % 255 + 1);
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int c = 0; c < `MOTION_NPWM; c++)
			send_frame(OP_PWM, 8'(c), {8'd0, duty[c]});
		send_frame(OP_CLEAR, 8'd0, 16'd0); // Disarms the watchdog for the long windows.
		measure_pwm("duty window", 1'b0);

		run_move("move up", 0, 1'b1, 9);
		run_move("move down", 0, 1'b0, 4);
		run_move("zero move", 0, 1'b1, 0);
		run_move("move down again", 0, 1'b0, 6);

		base0 = step_cnt[0];
		base1 = step_cnt[1];
		exp_dir = 2'b01;
		send_frame(OP_MOVE, 8'd0, {1'b1, 15'd20});
		send_frame(OP_MOVE, 8'd1, {1'b0, 15'd12});
		send_frame(OP_MOVE, 8'd0, {1'b0, 15'd3});
		@(negedge clk);
		check_value("busy axis stall", 0, msg_ready);
		while (!msg_ready)
			@(negedge clk);
		check_value("stall end axis 0 steps", step_total(20), step_cnt[0] - base0);
		check_value("concurrent axis 1 steps", step_total(12), step_cnt[1] - base1);
		exp_dir[0] = 1'b0;
		while (step_cnt[0] < base0 + step_total(20) + step_total(3))
			@(negedge clk);
		repeat (`STEP_HIGH_CYCLES + `STEP_LOW_CYCLES + 2) @(negedge clk);
		exp_pos[0] = end_position(end_position(exp_pos[0], 1'b1, 20), 1'b0, 3);
		exp_pos[1] = end_position(exp_pos[1], 1'b0, 12);
		check_value("two axis total steps", 23, step_cnt[0] - base0);
		check_value("two axis position 0", exp_pos[0], position[0]);
		check_value("two axis position 1", exp_pos[1], position[1]);

		base0 = step_cnt[0];
		exp_dir[0] = 1'b1;
		send_frame(OP_MOVE, 8'd0, {1'b1, 15'd30});
		while (step_cnt[0] < base0 + 5)
			@(negedge clk);
		endstop[0] = 1'b1;
		@(negedge clk);
		check_value("endstop shutdown", 1, shutdown);
		check_value("endstop cause", shutdown_cause(1'b1, 1'b0), cause);
		endstop[0] = 1'b0;
		taken = step_cnt[0] - base0;
		measure_pwm("endstop masked pwm", 1'b1);
		check_value("steps after endstop", taken, step_cnt[0] - base0);
		assert (taken < 30) else begin
			other_errors++;
			$display("Endstop did not cut the move short");
		end
		exp_pos[0] = exp_pos[0] + taken; // One count per visible rising step.
		check_value("endstop position", exp_pos[0], position[0]);
		send_frame(OP_CLEAR, 8'd0, 16'd0);
		@(negedge clk);
		check_value("clear shutdown", 0, shutdown);
		check_value("clear cause", CAUSE_NONE, cause);
		run_move("move after clear", 0, 1'b0, 4);
		measure_pwm("pwm after clear", 1'b0);

		send_frame(OP_PWM, 8'd0, {8'd0, duty[0]});
		silent = 0;
		while (!shutdown) begin
			@(negedge clk);
			silent++;
		end
		assert (silent > `WATCHDOG_CYCLES && silent <= `WATCHDOG_CYCLES + 8) else begin
			other_errors++;
			$display("Watchdog shutdown came after %0d silent cycles, not just past the limit",
				silent);
		end
		check_value("watchdog cause", shutdown_cause(1'b0, 1'b1), cause);
		send_frame(OP_CLEAR, 8'd0, 16'd0);
		@(negedge clk);
		check_value("watchdog clear", 0, shutdown);

		send_frame(8'h7e, 8'd0, 16'h1234);
		check_value("bad opcode frame_error", 1, frame_error);
		run_move("move after bad frame", 1, 1'b1, 3);
		duty[2] = 8'({$random(seed)} % 255 + 1);
		send_frame(OP_PWM, 8'd2, {8'd0, duty[2]});
		send_frame(OP_CLEAR, 8'd0, 16'd0);
		measure_pwm("pwm after bad frame", 1'b0);

		$display("Errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
			motion_io_i.checker_i.failures);
		if (error_total() == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
